// File: files.f
hdl/bfs_reduce_pkg.sv
hdl/reduce_stage_if.sv
hdl/reduce_stage.sv
hdl/bfs_min_reduce.sv
testbench/bfs_min_reduce_checker.sv
testbench/tb_bfs_min_reduce.sv

// File: hdl/bfs_min_reduce.sv
// segmented min over lanes, log2(lanes) cycles latency; lanes a power of two >= 2, no back-pressure.
module bfs_min_reduce #(
    parameter int lanes        = bfs_reduce_pkg::default_lanes,
    parameter int value_width  = bfs_reduce_pkg::default_value_width,
    parameter int acc_id_width = bfs_reduce_pkg::default_acc_id_width,
    parameter int dst_channels = bfs_reduce_pkg::default_dst_channels,
    parameter int dst_id_width = bfs_reduce_pkg::default_dst_id_width,
    parameter int mask_width   = bfs_reduce_pkg::default_mask_width
) (
    input  logic                                 clk,
    input  logic                                 rst,

    // edge lanes, lane 0 in the low bits.
    input  logic [lanes*value_width-1:0]         front_src,
    input  logic [lanes*acc_id_width-1:0]        front_acc_id,
    input  logic                                 front_src_valid,

    // destination channels, channel 0 in the low bits.
    input  logic [dst_channels*dst_id_width-1:0] front_dst_id,
    input  logic [dst_channels*mask_width-1:0]   front_src_mask,
    input  logic [dst_channels-1:0]              front_dst_valid,

    // reduced lanes, each the min of its trailing same-id run.
    output logic [lanes*value_width-1:0]         src,
    output logic                                 src_valid,

    output logic [dst_channels*dst_id_width-1:0] dst_id,
    output logic [dst_channels*mask_width-1:0]   src_mask,
    output logic [dst_channels-1:0]              dst_valid
);

    import bfs_reduce_pkg::*;

    localparam int levels = level_count(lanes);   // also the latency in cycles.

    if (lanes < 2 || (lanes & (lanes - 1)) != 0) begin : g_bad_lanes
        $error("bfs_min_reduce: lanes = %0d, must be a power of two of at least 2", lanes);
    end

    // bus k feeds stage k, bus levels is the final result.
    reduce_stage_if #(
        .lanes        (lanes),
        .value_width  (value_width),
        .acc_id_width (acc_id_width),
        .dst_channels (dst_channels),
        .dst_id_width (dst_id_width),
        .mask_width   (mask_width)
    ) stage_bus [0:levels] ();

    assign stage_bus[0].vals      = front_src;
    assign stage_bus[0].ids       = front_acc_id;
    assign stage_bus[0].src_valid = front_src_valid;
    assign stage_bus[0].dst_id    = front_dst_id;
    assign stage_bus[0].src_mask  = front_src_mask;
    assign stage_bus[0].dst_valid = front_dst_valid;

    for (genvar k = 0; k < levels; k++) begin : g_stage
        reduce_stage #(
            .level        (k),
            .lanes        (lanes),
            .value_width  (value_width),
            .acc_id_width (acc_id_width),
            .dst_channels (dst_channels),
            .dst_id_width (dst_id_width),
            .mask_width   (mask_width)
        ) i_reduce_stage (
            .clk  (clk),
            .rst  (rst),
            .up   (stage_bus[k]),
            .down (stage_bus[k+1])
        );
    end

    // ids are unchanged end to end, so the last bus ids go nowhere.
    assign src       = stage_bus[levels].vals;
    assign src_valid = stage_bus[levels].src_valid;
    assign dst_id    = stage_bus[levels].dst_id;
    assign src_mask  = stage_bus[levels].src_mask;
    assign dst_valid = stage_bus[levels].dst_valid;

endmodule

// File: hdl/bfs_reduce_pkg.sv
// default sizes for the BFS min reducer; the lane count must be a power of two of at least 2.
package bfs_reduce_pkg;

    // edge lanes reduced per cycle.
    localparam int default_lanes = 16;

    // one lane value, the BFS level or distance.
    localparam int default_value_width = 32;

    // accumulator id carried with each lane.
    localparam int default_acc_id_width = 4;

    // sideband destination channels.
    localparam int default_dst_channels = 4;
    localparam int default_dst_id_width = 32;
    localparam int default_mask_width   = 8;

    // number of prefix levels for a lane count, i.e. log2(lanes).
    // rounds up when lanes is not a power of two. the top level rejects that case.
    function automatic int level_count(input int lanes);
        int n;
        n = 0;
        while ((1 << n) < lanes) begin
            n++;
        end
        return n;
    endfunction

endpackage

// File: hdl/reduce_stage.sv
// one prefix level, one cycle of latency; level must lie below log2(lanes), no stall input.
module reduce_stage #(
    parameter int level        = 0,
    parameter int lanes        = bfs_reduce_pkg::default_lanes,
    parameter int value_width  = bfs_reduce_pkg::default_value_width,
    parameter int acc_id_width = bfs_reduce_pkg::default_acc_id_width,
    parameter int dst_channels = bfs_reduce_pkg::default_dst_channels,
    parameter int dst_id_width = bfs_reduce_pkg::default_dst_id_width,
    parameter int mask_width   = bfs_reduce_pkg::default_mask_width
) (
    input logic              clk,
    input logic              rst,
    reduce_stage_if.consumer up,
    reduce_stage_if.producer down
);

    import bfs_reduce_pkg::*;

    localparam int half  = 1 << level;   // lanes in each half of a block.
    localparam int block = half << 1;

    // unpacked views of the incoming lanes.
    logic [value_width-1:0]  val_in  [lanes];
    logic [acc_id_width-1:0] id_in   [lanes];
    logic [value_width-1:0]  val_nxt [lanes];

    // bit i set when lane i has the same id as lane i-1.
    logic [lanes-1:1] same_left;

    logic [lanes*value_width-1:0]         vals_q;
    logic [lanes*acc_id_width-1:0]        ids_q;
    logic                                 src_valid_q;
    logic [dst_channels*dst_id_width-1:0] dst_id_q;
    logic [dst_channels*mask_width-1:0]   src_mask_q;
    logic [dst_channels-1:0]              dst_valid_q;

    if (level < 0 || level >= level_count(lanes)) begin : g_bad_level
        $error("reduce_stage: level %0d out of range for %0d lanes", level, lanes);
    end

    for (genvar i = 0; i < lanes; i++) begin : g_lane
        localparam int base    = (i / block) * block;
        localparam int partner = base + half - 1;   // top lane of the lower half.

        assign val_in[i] = up.vals[i*value_width +: value_width];
        assign id_in[i]  = up.ids[i*acc_id_width +: acc_id_width];

        if (i > 0) begin : g_rest
            assign same_left[i] = (id_in[i] == id_in[i-1]);
        end

        if (i - base >= half) begin : g_upper
            logic joined;
            logic take;

            // equal end ids are not enough when an id repeats further apart.
            // the run must stay unbroken all the way down to the partner.
            assign joined = &same_left[i -: (i - partner)];

            // lower value wins only when strictly smaller.
            assign take       = joined && (val_in[partner] < val_in[i]);
            assign val_nxt[i] = take ? val_in[partner] : val_in[i];
        end else begin : g_lower
            assign val_nxt[i] = val_in[i];   // lower half just registers.
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            vals_q      <= '0;
            ids_q       <= '0;
            src_valid_q <= 1'b0;
            dst_id_q    <= '0;
            src_mask_q  <= '0;
            dst_valid_q <= '0;
        end else begin
            for (int i = 0; i < lanes; i++) begin
                vals_q[i*value_width +: value_width] <= val_nxt[i];
            end
            ids_q       <= up.ids;          // ids never change along the path.
            src_valid_q <= up.src_valid;

            // sideband rides along so it stays aligned with the lanes.
            dst_id_q    <= up.dst_id;
            src_mask_q  <= up.src_mask;
            dst_valid_q <= up.dst_valid;
        end
    end

    assign down.vals      = vals_q;
    assign down.ids       = ids_q;
    assign down.src_valid = src_valid_q;
    assign down.dst_id    = dst_id_q;
    assign down.src_mask  = src_mask_q;
    assign down.dst_valid = dst_valid_q;

endmodule

// File: hdl/reduce_stage_if.sv
// one level's lane and sideband bundle; no handshake, every field is valid in the same cycle.
interface reduce_stage_if #(
    parameter int lanes        = bfs_reduce_pkg::default_lanes,
    parameter int value_width  = bfs_reduce_pkg::default_value_width,
    parameter int acc_id_width = bfs_reduce_pkg::default_acc_id_width,
    parameter int dst_channels = bfs_reduce_pkg::default_dst_channels,
    parameter int dst_id_width = bfs_reduce_pkg::default_dst_id_width,
    parameter int mask_width   = bfs_reduce_pkg::default_mask_width
);

    // edge lanes, lane 0 in the low bits.
    logic [lanes*value_width-1:0]  vals;
    logic [lanes*acc_id_width-1:0] ids;
    logic                          src_valid;   // strobe for the whole lane word.

    // destination channels, channel 0 in the low bits.
    logic [dst_channels*dst_id_width-1:0] dst_id;
    logic [dst_channels*mask_width-1:0]   src_mask;
    logic [dst_channels-1:0]              dst_valid;   // one strobe per channel.

    modport producer (
        output vals,
        output ids,
        output src_valid,
        output dst_id,
        output src_mask,
        output dst_valid
    );

    modport consumer (
        input vals,
        input ids,
        input src_valid,
        input dst_id,
        input src_mask,
        input dst_valid
    );

endinterface

// File: testbench/bfs_min_reduce_checker.sv
// latency and reset assertions for bfs_min_reduce; only lane 0 of src is compared.
module bfs_min_reduce_checker #(
    parameter int lanes        = bfs_reduce_pkg::default_lanes,
    parameter int value_width  = bfs_reduce_pkg::default_value_width,
    parameter int dst_channels = bfs_reduce_pkg::default_dst_channels
) (
    input logic                           clk,
    input logic                           rst,
    input logic [lanes*value_width-1:0]   front_src,
    input logic                           front_src_valid,
    input logic [dst_channels-1:0]        front_dst_valid,
    input logic [lanes*value_width-1:0]   src,
    input logic                           src_valid,
    input logic [dst_channels-1:0]        dst_valid
);

    import bfs_reduce_pkg::*;

    localparam int levels = level_count(lanes);

    int settled;   // cycles since reset, stops at levels.

    always_ff @(posedge clk) begin
        if (rst) begin
            settled <= 0;
        end else if (settled < levels) begin
            settled <= settled + 1;
        end
    end

    a_src_valid_delay: assert property (@(posedge clk) disable iff (rst)
        (settled == levels) |-> src_valid == $past(front_src_valid, levels))
        else $error("src_valid does not follow front_src_valid by %0d cycles", levels);

    a_dst_valid_delay: assert property (@(posedge clk) disable iff (rst)
        (settled == levels) |-> dst_valid == $past(front_dst_valid, levels))
        else $error("dst_valid does not follow front_dst_valid by %0d cycles", levels);

    // lane 0 has no left neighbor, so it passes straight through.
    a_lane0_delay: assert property (@(posedge clk) disable iff (rst)
        (settled == levels) |->
            src[value_width-1:0] == $past(front_src[value_width-1:0], levels))
        else $error("src lane 0 does not follow front_src lane 0 by %0d cycles", levels);

    a_reset_clears: assert property (@(posedge clk) rst |=> (!src_valid && dst_valid == '0))
        else $error("valids not cleared one cycle after reset");

endmodule

bind bfs_min_reduce bfs_min_reduce_checker #(
    .lanes        (lanes),
    .value_width  (value_width),
    .dst_channels (dst_channels)
) i_bfs_min_reduce_checker (
    .clk             (clk),
    .rst             (rst),
    .front_src       (front_src),
    .front_src_valid (front_src_valid),
    .front_dst_valid (front_dst_valid),
    .src             (src),
    .src_valid       (src_valid),
    .dst_valid       (dst_valid)
);

// File: testbench/tb_bfs_min_reduce.sv
// directed tests at the package default sizes; latency is level_count(lanes), sampled at negedge.
module tb_bfs_min_reduce;

    import bfs_reduce_pkg::*;

    localparam int lanes = default_lanes;
    localparam int vw    = default_value_width;
    localparam int iw    = default_acc_id_width;
    localparam int ch    = default_dst_channels;
    localparam int dw    = default_dst_id_width;
    localparam int mw    = default_mask_width;
    localparam int lat   = level_count(lanes);

    // reset plus 63 items with 2*lat idle cycles per run stays near 120 cycles.
    localparam int max_cycles = 2000;

    logic                clk = 1'b0;
    logic                rst;
    logic [lanes*vw-1:0] front_src;
    logic [lanes*iw-1:0] front_acc_id;
    logic                front_src_valid;
    logic [ch*dw-1:0]    front_dst_id;
    logic [ch*mw-1:0]    front_src_mask;
    logic [ch-1:0]       front_dst_valid;
    logic [lanes*vw-1:0] src;
    logic                src_valid;
    logic [ch*dw-1:0]    dst_id;
    logic [ch*mw-1:0]    src_mask;
    logic [ch-1:0]       dst_valid;

    int          error_count = 0;
    int          cycle_count = 0;
    logic [31:0] rng_state   = 32'hf2e9_c26c;

    // items queued by a test, then driven one per cycle.
    logic [lanes*vw-1:0] stim_src [$];
    logic [lanes*iw-1:0] stim_id  [$];
    logic                stim_sv  [$];
    logic [ch*dw-1:0]    stim_dst [$];
    logic [ch*mw-1:0]    stim_mask [$];
    logic [ch-1:0]       stim_dv  [$];

    bfs_min_reduce i_bfs_min_reduce (
        .clk             (clk),
        .rst             (rst),
        .front_src       (front_src),
        .front_acc_id    (front_acc_id),
        .front_src_valid (front_src_valid),
        .front_dst_id    (front_dst_id),
        .front_src_mask  (front_src_mask),
        .front_dst_valid (front_dst_valid),
        .src             (src),
        .src_valid       (src_valid),
        .dst_id          (dst_id),
        .src_mask        (src_mask),
        .dst_valid       (dst_valid)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            $display("ERROR: timeout, run did not finish within %0d cycles", max_cycles);
            $display("Result: FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    // running min that restarts wherever the id changes from the lane below.
    function automatic logic [lanes*vw-1:0] trailing_min(input logic [lanes*vw-1:0] vals,
                                                         input logic [lanes*iw-1:0] ids);
        logic [lanes*vw-1:0] res;
        logic [vw-1:0]       run_min;
        logic [vw-1:0]       v;
        res     = '0;
        run_min = '0;
        for (int i = 0; i < lanes; i++) begin
            v = vals[i*vw +: vw];
            if (i == 0) begin
                run_min = v;
            end else if (ids[i*iw +: iw] != ids[(i-1)*iw +: iw]) begin
                run_min = v;
            end else if (v < run_min) begin
                run_min = v;
            end
            res[i*vw +: vw] = run_min;
        end
        return res;
    endfunction

    task automatic push_item(input logic [lanes*vw-1:0] vals, input logic [lanes*iw-1:0] ids,
                             input logic sv, input logic [ch*dw-1:0] dst,
                             input logic [ch*mw-1:0] mask, input logic [ch-1:0] dv);
        stim_src.push_back(vals);
        stim_id.push_back(ids);
        stim_sv.push_back(sv);
        stim_dst.push_back(dst);
        stim_mask.push_back(mask);
        stim_dv.push_back(dv);
    endtask

    // drives the queued items then idles, checking every output item lat cycles later.
    task automatic run_items(input string name);
        logic [lanes*vw-1:0] exp_src  [$];
        logic                exp_sv   [$];
        logic [ch*dw-1:0]    exp_dst  [$];
        logic [ch*mw-1:0]    exp_mask [$];
        logic [ch-1:0]       exp_dv   [$];
        logic [lanes*vw-1:0] e_src;
        int                  n;
        n = stim_src.size();
        for (int c = 0; c < n + 2*lat; c++) begin
            @(posedge clk);
            if (c < n) begin
                front_src       <= stim_src[c];
                front_acc_id    <= stim_id[c];
                front_src_valid <= stim_sv[c];
                front_dst_id    <= stim_dst[c];
                front_src_mask  <= stim_mask[c];
                front_dst_valid <= stim_dv[c];
                exp_src.push_back(trailing_min(stim_src[c], stim_id[c]));
                exp_sv.push_back(stim_sv[c]);
                exp_dst.push_back(stim_dst[c]);
                exp_mask.push_back(stim_mask[c]);
                exp_dv.push_back(stim_dv[c]);
            end else begin
                front_src       <= '0;
                front_acc_id    <= '0;
                front_src_valid <= 1'b0;
                front_dst_id    <= '0;
                front_src_mask  <= '0;
                front_dst_valid <= '0;
                exp_src.push_back('0);
                exp_sv.push_back(1'b0);
                exp_dst.push_back('0);
                exp_mask.push_back('0);
                exp_dv.push_back('0);
            end
            @(negedge clk);
            if (c < lat) begin
                if (src_valid !== 1'b0 || dst_valid !== '0) begin
                    $display("ERROR: %s: a valid rose before the first item could arrive", name);
                    error_count++;
                end
            end else begin
                e_src = exp_src.pop_front();
                for (int i = 0; i < lanes; i++) begin
                    if (src[i*vw +: vw] !== e_src[i*vw +: vw]) begin
                        $display("[FAIL] %s: item %0d lane %0d expected %0h, got %0h",
                                 name, c - lat, i, e_src[i*vw +: vw], src[i*vw +: vw]);
                        error_count++;
                    end
                end
                if (src_valid !== exp_sv[0]) begin
                    $display("[FAIL] %s: item %0d src_valid expected %b, got %b",
                             name, c - lat, exp_sv[0], src_valid);
                    error_count++;
                end
                if (dst_id !== exp_dst[0] || src_mask !== exp_mask[0] ||
                    dst_valid !== exp_dv[0]) begin
                    $display("[FAIL] %s: item %0d sideband expected %0h/%0h/%0h, got %0h/%0h/%0h",
                             name, c - lat, exp_dst[0], exp_mask[0], exp_dv[0],
                             dst_id, src_mask, dst_valid);
                    error_count++;
                end
                void'(exp_sv.pop_front());
                void'(exp_dst.pop_front());
                void'(exp_mask.pop_front());
                void'(exp_dv.pop_front());
            end
        end
        stim_src.delete();
        stim_id.delete();
        stim_sv.delete();
        stim_dst.delete();
        stim_mask.delete();
        stim_dv.delete();
    endtask

    task automatic reset_test();
        for (int c = 0; c < 16 + lat; c++) begin
            @(posedge clk);
            if (c == 15) begin
                rst <= 1'b0;   // 16 edges seen with rst high.
            end
            @(negedge clk);
            if (src_valid !== 1'b0 || dst_valid !== '0 || src !== '0) begin
                $display("[FAIL] reset: cycle %0d expected valids 0 and src 0, got %b %b %0h",
                         c, src_valid, dst_valid, src);
                error_count++;
            end
        end
    endtask

    task automatic single_acc_test();
        logic [lanes*vw-1:0] vals;
        logic [lanes*iw-1:0] ids;
        for (int i = 0; i < lanes; i++) begin
            vals[i*vw +: vw] = next_rand();
            ids[i*iw +: iw]  = 4'h5;
        end
        push_item(vals, ids, 1'b1, '0, '0, '0);
        run_items("single_acc");
    endtask

    task automatic distinct_ids_test();
        logic [lanes*vw-1:0] vals;
        logic [lanes*iw-1:0] ids;
        logic [31:0]         base;
        base = next_rand() & 32'h00ff_ffff;
        for (int i = 0; i < lanes; i++) begin
            vals[i*vw +: vw] = base + i * 3;   // left neighbor always smaller.
            ids[i*iw +: iw]  = i;
        end
        push_item(vals, ids, 1'b1, '0, '0, '0);
        for (int i = 0; i < lanes; i++) begin
            vals[i*vw +: vw] = next_rand();
        end
        push_item(vals, ids, 1'b1, '0, '0, '0);
        run_items("distinct_ids");
    endtask

    task automatic random_runs_test();
        logic [lanes*vw-1:0] vals;
        logic [lanes*iw-1:0] ids;
        logic [ch*dw-1:0]    dst;
        logic [31:0]         r;
        logic [iw-1:0]       cur;
        cur = '0;
        for (int k = 0; k < 40; k++) begin
            for (int i = 0; i < lanes; i++) begin
                r = next_rand();
                if (i == 0 || r[1:0] == 2'b00) begin
                    cur = r[5:4];   // ids from a set of four.
                end
                ids[i*iw +: iw]  = cur;
                vals[i*vw +: vw] = r[2] ? (next_rand() & 32'hf) : next_rand();
            end
            for (int j = 0; j < ch; j++) begin
                dst[j*dw +: dw] = next_rand();
            end
            push_item(vals, ids, 1'b1, dst, next_rand(), '1);
        end
        run_items("random_runs");
    endtask

    task automatic sideband_test();
        logic [lanes*vw-1:0] vals;
        logic [lanes*iw-1:0] ids;
        logic [ch*dw-1:0]    dst;
        logic [31:0]         r;
        for (int k = 0; k < 20; k++) begin
            for (int i = 0; i < lanes; i++) begin
                vals[i*vw +: vw] = next_rand();
                ids[i*iw +: iw]  = next_rand();
            end
            for (int j = 0; j < ch; j++) begin
                dst[j*dw +: dw] = next_rand();
            end
            r = next_rand();
            push_item(vals, ids, r[0], dst, next_rand(), r[7:4]);
        end
        run_items("sideband");
    endtask

    initial begin
        rst             = 1'b1;
        front_src       = '0;
        front_acc_id    = '0;
        front_src_valid = 1'b0;
        front_dst_id    = '0;
        front_src_mask  = '0;
        front_dst_valid = '0;
        reset_test();
        single_acc_test();
        distinct_ids_test();
        random_runs_test();
        sideband_test();
        $display("tests done after %0d cycles, %0d errors", cycle_count, error_count);
        if (error_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
